/* src/radio_pkg.sv */
// radio core shared definitions
`default_nettype none

package radio_pkg;

   // --------------------
   // widths and types
   // --------------------
   localparam int SAMPLE_W   = 32;
   localparam int IQ_W       = 16;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_DATA_W  = 64;
   localparam int LED_W      = 3;

   typedef logic [SAMPLE_W-1:0]    sample_t;     // {i, q}
   typedef logic signed [IQ_W-1:0] iq_t;
   typedef logic [SET_ADDR_W-1:0]  set_addr_t;
   typedef logic [SET_DATA_W-1:0]  set_data_t;
   typedef logic [RB_DATA_W-1:0]   rb_data_t;    // {upper word, lower word}

   // front-end correction, swap happens before the q negation
   typedef struct packed {
      logic inv_q;   // bit 1
      logic swap;    // bit 0
   } fe_ctrl_t;

   typedef enum logic {
      TX_SRC_HOST = 1'b0,
      TX_SRC_CHIP = 1'b1
   } tx_src_e;

   // --------------------
   // register map
   // --------------------
   localparam set_addr_t SR_DB_BASE        = 8'd160;
   localparam set_addr_t RB_DB_BASE        = 8'd16;
   localparam set_addr_t SR_FE_CHAN_OFFSET = 8'd16;
   localparam set_addr_t SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;   // 208
   localparam set_addr_t SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;   // 224

   typedef enum logic [2:0] {
      REG_GPIO_OUT = 3'd0,
      REG_GPIO_DDR = 3'd1,
      REG_LEDS     = 3'd2,
      REG_MISC_OUT = 3'd3,
      REG_TX_SRC   = 3'd4
   } db_reg_e;

   typedef enum logic [0:0] {
      RB_MISC_GPIO = 1'b0,   // {misc in, db gpio in}
      RB_CTRL      = 1'b1    // {misc out, tx src at bit 4, leds}
   } rb_sel_e;

   localparam int RB_TX_SRC_BIT = 4;

   // module parameter defaults
   localparam int DEF_NUM_DBOARDS = 2;
   localparam int DEF_LFSR_WIDTH  = 9;

endpackage

`default_nettype wire

/* src/db_control.sv */
// daughterboard control registers
`timescale 1ns/1ps
`default_nettype none

module db_control
   import radio_pkg::*;
(
   input  wire logic      i_rst_n,
   input  wire logic      radio_clk,
   // settings bus
   input  wire logic      i_set_stb,
   input  wire set_addr_t i_set_addr,
   input  wire set_data_t i_set_data,
   // readback
   input  wire set_addr_t i_rb_addr,
   output rb_data_t       o_rb_data,
   // board pins
   input  wire logic [31:0] i_misc_in,
   output logic [31:0]      o_misc_out,
   input  wire logic [31:0] i_gpio_in,
   output logic [31:0]      o_gpio_out,
   output logic [31:0]      o_gpio_ddr,
   output logic [LED_W-1:0] o_leds,
   output logic             o_tx_src
);

   set_addr_t   set_off;
   set_addr_t   rb_off;
   tx_src_e     tx_src;
   logic [31:0] misc_in_q;
   logic [31:0] ctrl_word;

   assign set_off  = i_set_addr - SR_DB_BASE;   // addresses below base wrap high
   assign rb_off   = i_rb_addr - RB_DB_BASE;
   assign o_tx_src = (tx_src == TX_SRC_CHIP);

   // --------------------
   // register file
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
         o_leds     <= '0;
         o_misc_out <= '0;
         tx_src     <= TX_SRC_HOST;
      end else if (i_set_stb) begin
         case (set_off)
            set_addr_t'(REG_GPIO_OUT): o_gpio_out <= i_set_data;
            set_addr_t'(REG_GPIO_DDR): o_gpio_ddr <= i_set_data;
            set_addr_t'(REG_LEDS):     o_leds     <= i_set_data[LED_W-1:0];
            set_addr_t'(REG_MISC_OUT): o_misc_out <= i_set_data;
            set_addr_t'(REG_TX_SRC):   tx_src     <= tx_src_e'(i_set_data[0]);
            default: ;   // fe_control space or unmapped
         endcase
      end
   end

   // misc inputs sampled every cycle
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         misc_in_q <= '0;
      end else begin
         misc_in_q <= i_misc_in;
      end
   end

   // --------------------
   // readback
   // --------------------
   always_comb begin
      ctrl_word                   = '0;
      ctrl_word[LED_W-1:0]        = o_leds;
      ctrl_word[RB_TX_SRC_BIT]    = o_tx_src;
   end

   // data is valid one cycle after the address
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_data <= '0;
      end else begin
         case (rb_off)
            set_addr_t'(RB_MISC_GPIO): o_rb_data <= {misc_in_q, i_gpio_in};
            set_addr_t'(RB_CTRL):      o_rb_data <= {o_misc_out, ctrl_word};
            default:                   o_rb_data <= '0;
         endcase
      end
   end

   // inputs from the board pins may float before reset completes
   a_rb_known : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $past(i_rst_n) |-> !$isunknown(o_rb_data))
      else $error("db_control: readback word unknown after reset");

endmodule

`default_nettype wire

/* src/fe_control.sv */
// front-end IQ correction
`timescale 1ns/1ps
`default_nettype none

module fe_control
   import radio_pkg::*;
(
   input  wire logic      radio_clk,
   input  wire logic      i_rst_n,
   // settings bus
   input  wire logic      i_set_stb,
   input  wire set_addr_t i_set_addr,
   input  wire set_data_t i_set_data,
   // samples
   input  wire sample_t   i_rx,
   output sample_t        o_rx0,
   output sample_t        o_rx1,
   input  wire sample_t   i_tx,
   output sample_t        o_tx
);

   localparam int        NUM_RX    = 2;
   localparam int        FE_CTRL_W = $bits(fe_ctrl_t);
   localparam set_addr_t TX_ADDR   = SR_TX_FE_BASE;

   fe_ctrl_t rx_ctrl [NUM_RX];
   fe_ctrl_t tx_ctrl;

   // rx channel k control address
   function automatic set_addr_t rx_addr(input int k);
      return set_addr_t'(SR_RX_FE_BASE + k * SR_FE_CHAN_OFFSET);
   endfunction

   // swap first, then negate q
   function automatic sample_t fe_correct(input sample_t s, input fe_ctrl_t c);
      iq_t i_part;
      iq_t q_part;
      i_part = c.swap ? s[IQ_W-1:0] : s[SAMPLE_W-1:IQ_W];
      q_part = c.swap ? s[SAMPLE_W-1:IQ_W] : s[IQ_W-1:0];
      if (c.inv_q) begin
         q_part = -q_part;   // full-scale negative wraps onto itself
      end
      return {i_part, q_part};
   endfunction

   // --------------------
   // control registers
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rx_ctrl <= '{default: '0};
         tx_ctrl <= '0;
      end else if (i_set_stb) begin
         for (int k = 0; k < NUM_RX; k++) begin
            if (i_set_addr == rx_addr(k)) begin
               rx_ctrl[k] <= fe_ctrl_t'(i_set_data[FE_CTRL_W-1:0]);
            end
         end
         if (i_set_addr == TX_ADDR) begin
            tx_ctrl <= fe_ctrl_t'(i_set_data[FE_CTRL_W-1:0]);
         end
      end
   end

   // --------------------
   // corrected samples
   // --------------------
   always_ff @(posedge radio_clk) begin
      o_rx0 <= fe_correct(i_rx, rx_ctrl[0]);   // both channels see the same input
      o_rx1 <= fe_correct(i_rx, rx_ctrl[1]);
      o_tx  <= fe_correct(i_tx, tx_ctrl);
   end

   // control registers hold only known bits once out of reset
   a_ctrl_known : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $past(i_rst_n) |-> !$isunknown({rx_ctrl[0], rx_ctrl[1], tx_ctrl}))
      else $error("fe_control: control register holds unknown bits");

endmodule

`default_nettype wire

/* src/chip_source.sv */
// lfsr chip sequence source
`timescale 1ns/1ps
`default_nettype none

module chip_source
   import radio_pkg::*;
#(
   parameter int LFSR_WIDTH       = DEF_LFSR_WIDTH,
   parameter int SAMPLES_PER_CHIP = 4,
   parameter int CHIP_AMPLITUDE   = 8192
)(
   input  wire logic radio_clk,
   input  wire logic i_rst_n,
   input  wire logic i_run,
   output sample_t   o_sample,   // {+/-amplitude, 0}
   output logic      o_chip,
   output logic      o_wrap
);

   localparam int               TAP      = 5;   // x^9 + x^5 + 1
   localparam int               CNT_W    = (SAMPLES_PER_CHIP > 1) ?
                                           $clog2(SAMPLES_PER_CHIP) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLES_PER_CHIP - 1);
   localparam iq_t              AMP_POS  = iq_t'(CHIP_AMPLITUDE);
   localparam iq_t              AMP_NEG  = iq_t'(-CHIP_AMPLITUDE);

   logic [LFSR_WIDTH-1:0] lfsr;
   logic [LFSR_WIDTH-1:0] lfsr_next;
   logic [CNT_W-1:0]      chip_cnt;
   logic                  chip_end;
   logic                  chip_bit;

   assign lfsr_next = {lfsr[LFSR_WIDTH-2:0], lfsr[LFSR_WIDTH-1] ^ lfsr[TAP-1]};
   assign chip_end  = (chip_cnt == CNT_LAST);
   assign chip_bit  = lfsr[LFSR_WIDTH-1];

   // --------------------
   // sequencer
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n || !i_run) begin
         lfsr     <= '1;   // idle seed
         chip_cnt <= '0;
      end else if (chip_end) begin
         lfsr     <= lfsr_next;
         chip_cnt <= '0;
      end else begin
         chip_cnt <= chip_cnt + 1'b1;
      end
   end

   // outputs held at zero while idle
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_sample <= '0;
         o_chip   <= 1'b0;
         o_wrap   <= 1'b0;
      end else begin
         o_sample <= i_run ? {(chip_bit ? AMP_POS : AMP_NEG), iq_t'(0)} : '0;
         o_chip   <= i_run && chip_bit;
         o_wrap   <= i_run && chip_end && (lfsr_next == '1);   // back to seed
      end
   end

   a_lfsr_nonzero : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $past(i_rst_n) |-> (lfsr != '0))
      else $error("chip_source: lfsr locked at zero");

endmodule

`default_nettype wire

/* src/radio_core.sv */
// radio clock transceiver core
`timescale 1ns/1ps
`default_nettype none

module radio_core
   import radio_pkg::*;
#(
   parameter int NUM_DBOARDS      = DEF_NUM_DBOARDS,
   parameter int LFSR_WIDTH       = DEF_LFSR_WIDTH,
   parameter int SAMPLES_PER_CHIP = 4,
   parameter int CHIP_AMPLITUDE   = 8192
)(
   input  wire logic                   radio_clk,
   input  wire logic                   i_rst_n,
   // settings and readback, address and data shared by the boards
   input  wire logic [NUM_DBOARDS-1:0] i_set_stb,
   input  wire set_addr_t              i_set_addr,
   input  wire set_data_t              i_set_data,
   input  wire set_addr_t              i_rb_addr,
   output wire rb_data_t               o_rb_data [NUM_DBOARDS],
   // samples, rx channel k of board b at index 2*b+k
   input  wire sample_t                i_rx [NUM_DBOARDS],
   input  wire sample_t                i_tx [NUM_DBOARDS],
   output sample_t                     o_rx [2*NUM_DBOARDS],
   output sample_t                     o_tx [NUM_DBOARDS],
   // daughterboard pins
   input  wire logic [31:0]            i_db_gpio_in [NUM_DBOARDS],
   output logic [31:0]                 o_db_gpio_out [NUM_DBOARDS],
   output logic [31:0]                 o_db_gpio_ddr [NUM_DBOARDS],
   output logic [LED_W-1:0]            o_radio_led [NUM_DBOARDS],
   input  wire logic [31:0]            i_misc_in [NUM_DBOARDS],
   output logic [31:0]                 o_misc_out [NUM_DBOARDS],
   output logic [1:0]                  o_fp_gpio_out   // {wrap, chip}
);

   wire sample_t              chip_sample;
   wire logic                 chip_bit;
   wire logic                 chip_wrap;
   wire logic                 chip_run;
   wire [NUM_DBOARDS-1:0]     tx_src;
   wire sample_t              tx_fe_in  [NUM_DBOARDS];
   wire sample_t              tx_fe_out [NUM_DBOARDS];
   wire sample_t              rx_fe_out [2*NUM_DBOARDS];
   wire logic [31:0]          gpio_out  [NUM_DBOARDS];
   wire logic [31:0]          gpio_ddr  [NUM_DBOARDS];
   wire logic [31:0]          misc_out  [NUM_DBOARDS];
   wire logic [LED_W-1:0]     leds      [NUM_DBOARDS];

   assign chip_run = |tx_src;   // one shared sequence for every board

   chip_source #(
      .LFSR_WIDTH       (LFSR_WIDTH),
      .SAMPLES_PER_CHIP (SAMPLES_PER_CHIP),
      .CHIP_AMPLITUDE   (CHIP_AMPLITUDE)
   ) u_chip_source (
      .radio_clk (radio_clk),
      .i_rst_n   (i_rst_n),
      .i_run     (chip_run),
      .o_sample  (chip_sample),
      .o_chip    (chip_bit),
      .o_wrap    (chip_wrap)
   );

   // --------------------
   // board slices
   // --------------------
   for (genvar b = 0; b < NUM_DBOARDS; b++) begin : g_board
      assign tx_fe_in[b] = tx_src[b] ? chip_sample : i_tx[b];

      db_control u_db_control (
         .i_rst_n    (i_rst_n),
         .radio_clk  (radio_clk),
         .i_set_stb  (i_set_stb[b]),
         .i_set_addr (i_set_addr),
         .i_set_data (i_set_data),
         .i_rb_addr  (i_rb_addr),
         .o_rb_data  (o_rb_data[b]),
         .i_misc_in  (i_misc_in[b]),
         .o_misc_out (misc_out[b]),
         .i_gpio_in  (i_db_gpio_in[b]),
         .o_gpio_out (gpio_out[b]),
         .o_gpio_ddr (gpio_ddr[b]),
         .o_leds     (leds[b]),
         .o_tx_src   (tx_src[b])
      );

      fe_control u_fe_control (
         .radio_clk  (radio_clk),
         .i_rst_n    (i_rst_n),
         .i_set_stb  (i_set_stb[b]),
         .i_set_addr (i_set_addr),
         .i_set_data (i_set_data),
         .i_rx       (i_rx[b]),
         .o_rx0      (rx_fe_out[2*b]),
         .o_rx1      (rx_fe_out[2*b+1]),
         .i_tx       (tx_fe_in[b]),
         .o_tx       (tx_fe_out[b])
      );
   end

   // --------------------
   // output registers
   // --------------------
   always_ff @(posedge radio_clk) begin
      for (int b = 0; b < NUM_DBOARDS; b++) begin
         o_tx[b] <= tx_fe_out[b];
      end
      for (int c = 0; c < 2*NUM_DBOARDS; c++) begin
         o_rx[c] <= rx_fe_out[c];
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_db_gpio_out <= '{default: '0};
         o_db_gpio_ddr <= '{default: '0};
         o_radio_led   <= '{default: '0};
         o_misc_out    <= '{default: '0};
         o_fp_gpio_out <= '0;
      end else begin
         for (int b = 0; b < NUM_DBOARDS; b++) begin
            o_db_gpio_out[b] <= gpio_out[b];
            o_db_gpio_ddr[b] <= gpio_ddr[b];
            o_radio_led[b]   <= leds[b];
            o_misc_out[b]    <= misc_out[b];
         end
         o_fp_gpio_out <= {chip_wrap, chip_bit};   // front-panel markers
      end
   end

endmodule

`default_nettype wire

/* sim/radio_core_tb.sv */
// radio core testbench
`timescale 1ns/1ps
`default_nettype none

module radio_core_tb
   import radio_pkg::*;
();

   localparam int          NUM_DB   = 2;
   localparam int          LFSR_W   = 9;
   localparam int          LFSR_TAP = 4;   // x^5 term
   localparam int          SPC      = 4;   // samples per chip
   localparam int          AMP      = 8192;
   localparam int          MAX_CHIP = 4096;
   localparam logic [31:0] SEED     = 32'd59508;

   localparam set_addr_t A_GPIO_OUT = SR_DB_BASE + set_addr_t'(REG_GPIO_OUT);
   localparam set_addr_t A_GPIO_DDR = SR_DB_BASE + set_addr_t'(REG_GPIO_DDR);
   localparam set_addr_t A_LEDS     = SR_DB_BASE + set_addr_t'(REG_LEDS);
   localparam set_addr_t A_MISC_OUT = SR_DB_BASE + set_addr_t'(REG_MISC_OUT);
   localparam set_addr_t A_TX_SRC   = SR_DB_BASE + set_addr_t'(REG_TX_SRC);
   localparam set_addr_t A_RX0_FE   = SR_RX_FE_BASE;
   localparam set_addr_t A_RX1_FE   = SR_RX_FE_BASE + SR_FE_CHAN_OFFSET;
   localparam set_addr_t A_TX_FE    = SR_TX_FE_BASE;

   logic              radio_clk;
   logic              i_rst_n;
   logic [NUM_DB-1:0] i_set_stb;
   set_addr_t         i_set_addr;
   set_data_t         i_set_data;
   set_addr_t         i_rb_addr;
   rb_data_t          o_rb_data [NUM_DB];
   sample_t           i_rx [NUM_DB];
   sample_t           i_tx [NUM_DB];
   sample_t           o_rx [2*NUM_DB];
   sample_t           o_tx [NUM_DB];
   logic [31:0]       i_db_gpio_in [NUM_DB];
   logic [31:0]       o_db_gpio_out [NUM_DB];
   logic [31:0]       o_db_gpio_ddr [NUM_DB];
   logic [LED_W-1:0]  o_radio_led [NUM_DB];
   logic [31:0]       i_misc_in [NUM_DB];
   logic [31:0]       o_misc_out [NUM_DB];
   logic [1:0]        o_fp_gpio_out;

   // register model, one entry per board
   logic [31:0]       gpio_out_m [NUM_DB];
   logic [31:0]       gpio_ddr_m [NUM_DB];
   logic [2:0]        leds_m [NUM_DB];
   logic [31:0]       misc_out_m [NUM_DB];
   logic [1:0]        rx_fe_m [NUM_DB][2];
   logic [1:0]        tx_fe_m [NUM_DB];

   string             rec_name [$];
   string             rec_kind [$];
   int                rec_board [$];
   logic [31:0]       rec_a [$];
   logic [31:0]       rec_b [$];
   logic [31:0]       rec_c [$];
   logic [31:0]       rng = SEED;
   int                num_errors = 0;
   int                cycle_count = 0;
   int                cycle_limit = 3000;

   radio_core #(
      .NUM_DBOARDS      (NUM_DB),
      .LFSR_WIDTH       (LFSR_W),
      .SAMPLES_PER_CHIP (SPC),
      .CHIP_AMPLITUDE   (AMP)
   ) DUT (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_addr     (i_rb_addr),
      .o_rb_data     (o_rb_data),
      .i_rx          (i_rx),
      .i_tx          (i_tx),
      .o_rx          (o_rx),
      .o_tx          (o_tx),
      .i_db_gpio_in  (i_db_gpio_in),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_radio_led   (o_radio_led),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out),
      .o_fp_gpio_out (o_fp_gpio_out)
   );

   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk;
   end

   always @(posedge radio_clk) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count > cycle_limit);
      $display("Error: run did not finish within %0d cycles", cycle_limit);
      halt();
   end

   // --------------------
   // reference models
   // --------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ctrl bit 0 swaps i and q, bit 1 negates q afterwards
   function automatic sample_t corrected(input sample_t s, input logic [1:0] ctrl);
      logic [15:0] i_val;
      logic [15:0] q_val;
      logic [15:0] tmp;
      i_val = s[31:16];
      q_val = s[15:0];
      if (ctrl[0]) begin
         tmp   = i_val;
         i_val = q_val;
         q_val = tmp;
      end
      if (ctrl[1]) begin
         q_val = ~q_val + 16'd1;   // wraps at full scale
      end
      return {i_val, q_val};
   endfunction

   function automatic sample_t chip_word(input logic chip);
      logic [15:0] amp;
      amp = 16'(AMP);
      return {chip ? amp : (~amp + 16'd1), 16'h0000};
   endfunction

   task automatic update_model(input int b, input set_addr_t addr, input set_data_t data);
      case (addr)
         A_GPIO_OUT: gpio_out_m[b] = data;
         A_GPIO_DDR: gpio_ddr_m[b] = data;
         A_LEDS:     leds_m[b]     = data[2:0];
         A_MISC_OUT: misc_out_m[b] = data;
         A_RX0_FE:   rx_fe_m[b][0] = data[1:0];
         A_RX1_FE:   rx_fe_m[b][1] = data[1:0];
         A_TX_FE:    tx_fe_m[b]    = data[1:0];
         default: ;   // tx source and unmapped addresses
      endcase
   endtask

   // --------------------
   // compare tasks
   // --------------------
   task automatic halt();
      num_errors++;
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         halt();
      end
   endtask

   task automatic check_rb(input string name, input rb_data_t exp, input rb_data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         halt();
      end
   endtask

   task automatic check_pins(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         halt();
      end
   endtask

   task automatic check_all_pins(input string name);
      for (int k = 0; k < NUM_DB; k++) begin
         check_pins($sformatf("%s/gpio_out%0d", name, k), gpio_out_m[k], o_db_gpio_out[k]);
         check_pins($sformatf("%s/gpio_ddr%0d", name, k), gpio_ddr_m[k], o_db_gpio_ddr[k]);
         check_pins($sformatf("%s/leds%0d", name, k), 32'(leds_m[k]), 32'(o_radio_led[k]));
         check_pins($sformatf("%s/misc_out%0d", name, k), misc_out_m[k], o_misc_out[k]);
      end
   endtask

   // --------------------
   // stimulus tasks
   // --------------------
   task automatic write_reg(input int b, input set_addr_t addr, input set_data_t data);
      @(negedge radio_clk);
      i_set_stb  = NUM_DB'(1) << b;
      i_set_addr = addr;
      i_set_data = data;
      @(negedge radio_clk);
      i_set_stb = '0;
      update_model(b, addr, data);
   endtask

   task automatic read_rb(input string name, input int b, input set_addr_t addr,
                          input rb_data_t exp);
      @(negedge radio_clk);
      i_rb_addr = addr;
      @(negedge radio_clk);   // registered, one cycle later
      check_rb(name, exp, o_rb_data[b]);
   endtask

   // random samples, two cycles from input to output
   task automatic stream_samples(input string name, input int b, input int count,
                                 input bit tx_path);
      sample_t sent [$];
      sample_t s;
      for (int i = 0; i < count + 2; i++) begin
         @(negedge radio_clk);
         if (i >= 2) begin
            s = sent.pop_front();
            if (tx_path) begin
               check_sample($sformatf("%s[%0d]", name, i-2), corrected(s, tx_fe_m[b]),
                            o_tx[b]);
            end else begin
               check_sample($sformatf("%s/ch0[%0d]", name, i-2),
                            corrected(s, rx_fe_m[b][0]), o_rx[2*b]);
               check_sample($sformatf("%s/ch1[%0d]", name, i-2),
                            corrected(s, rx_fe_m[b][1]), o_rx[2*b+1]);
            end
         end
         if (i < count) begin
            rng = xorshift32(rng);
            sent.push_back(rng);
            if (tx_path) i_tx[b] = rng;
            else i_rx[b] = rng;
         end
      end
   endtask

   // cycle n counts edges after the one that loads the tx source
   task automatic run_chip(input string name, input int b, input int cycles);
      logic [LFSR_W-1:0] lfsr;
      logic [LFSR_W-1:0] lfsr_nx;
      logic              chips [MAX_CHIP];
      logic              wraps [MAX_CHIP];
      int                cnt;
      int                pulses;
      if (cycles >= MAX_CHIP) begin
         $display("Error: chip record %s asks for too many cycles", name);
         halt();
      end
      lfsr     = '1;
      cnt      = 0;
      pulses   = 0;
      chips[0] = 1'b0;
      wraps[0] = 1'b0;
      write_reg(b, A_TX_SRC, 32'd1);
      for (int n = 1; n <= cycles; n++) begin
         @(negedge radio_clk);
         chips[n] = lfsr[LFSR_W-1];
         wraps[n] = 1'b0;
         if (cnt == SPC - 1) begin
            lfsr_nx  = {lfsr[LFSR_W-2:0], lfsr[LFSR_W-1] ^ lfsr[LFSR_TAP]};
            wraps[n] = (lfsr_nx == '1);   // back at the seed
            lfsr     = lfsr_nx;
            cnt      = 0;
         end else begin
            cnt++;
         end
         check_pins($sformatf("%s/fp[%0d]", name, n), {30'd0, wraps[n-1], chips[n-1]},
                    {30'd0, o_fp_gpio_out});
         if (n >= 2) begin
            check_sample($sformatf("%s/tx[%0d]", name, n),
                         corrected((n == 2) ? '0 : chip_word(chips[n-2]), tx_fe_m[b]),
                         o_tx[b]);
         end
         if (o_fp_gpio_out[1]) pulses++;
      end
      if (pulses != 1) begin
         $display("Error: wrap pin pulsed %0d times in %s, expected once", pulses, name);
         halt();
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      int          fd;
      int          code;
      string       tok;
      string       line;
      string       kind;
      int          board;
      logic [31:0] fa;
      logic [31:0] fb;
      logic [31:0] fc;
      i_rst_n    = 1'b0;
      i_set_stb  = '0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rb_addr  = '0;
      for (int k = 0; k < NUM_DB; k++) begin
         i_rx[k]         = '0;
         i_tx[k]         = '0;
         i_db_gpio_in[k] = '0;
         i_misc_in[k]    = '0;
         gpio_out_m[k]   = '0;
         gpio_ddr_m[k]   = '0;
         leds_m[k]       = '0;
         misc_out_m[k]   = '0;
         rx_fe_m[k][0]   = '0;
         rx_fe_m[k][1]   = '0;
         tx_fe_m[k]      = '0;
      end

      fd = $fopen("sim/radio_core_golden.txt", "r");
      if (fd == 0) begin
         $display("Error: cannot open the golden file");
         halt();
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", tok);
         if (code == 1) begin
            if (tok.substr(0, 0) == "#") begin
               code = $fgets(line, fd);   // column notes
            end else begin
               code = $fscanf(fd, "%s %d %h %h %h", kind, board, fa, fb, fc);
               if (code != 5 || board < 0 || board >= NUM_DB) begin
                  $display("Error: golden record %s is malformed", tok);
                  halt();
               end
               rec_name.push_back(tok);
               rec_kind.push_back(kind);
               rec_board.push_back(board);
               rec_a.push_back(fa);
               rec_b.push_back(fb);
               rec_c.push_back(fc);
            end
         end
      end
      $fclose(fd);
      cycle_limit = rec_name.size() * 8 + 3000;

      repeat (5) @(negedge radio_clk);
      i_rst_n = 1'b1;
      check_all_pins("reset");
      check_pins("reset/fp", 32'd0, {30'd0, o_fp_gpio_out});

      for (int r = 0; r < rec_name.size(); r++) begin
         case (rec_kind[r])
            "write": begin
               write_reg(rec_board[r], rec_a[r][7:0], rec_b[r]);
               @(negedge radio_clk);   // pins follow one edge after the register
               check_all_pins(rec_name[r]);
            end
            "read": read_rb(rec_name[r], rec_board[r], rec_a[r][7:0], {rec_b[r], rec_c[r]});
            "drive": begin
               @(negedge radio_clk);
               i_misc_in[rec_board[r]]    = rec_b[r];
               i_db_gpio_in[rec_board[r]] = rec_c[r];
               @(negedge radio_clk);   // misc in is captured first
            end
            "rx": stream_samples(rec_name[r], rec_board[r], rec_a[r], 1'b0);
            "tx": stream_samples(rec_name[r], rec_board[r], rec_a[r], 1'b1);
            "chip": run_chip(rec_name[r], rec_board[r], rec_a[r]);
            default: begin
               $display("Error: unknown record kind %s", rec_kind[r]);
               halt();
            end
         endcase
      end

      @(negedge radio_clk);
      if (num_errors == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("Test failures found");
         $fatal(1, "errors were counted");
      end
   end

endmodule

`default_nettype wire

/* project.f */
src/radio_pkg.sv
src/db_control.sv
src/fe_control.sv
src/chip_source.sv
src/radio_core.sv
sim/radio_core_tb.sv

/* sim/radio_core_golden.txt */
# name kind board a b c, a b c in hex
# write a=addr b=data | read a=rb addr, expects {b,c} | drive b=misc_in c=gpio_in | rx tx chip a=cycles
rst_misc_b0 read 0 10 0 0
rst_ctrl_b0 read 0 11 0 0
rst_misc_b1 read 1 10 0 0
rst_ctrl_b1 read 1 11 0 0
rst_unmapped read 0 12 0 0
gpio_out_b0 write 0 a0 deadbeef 0
gpio_ddr_b0 write 0 a1 0000ffff 0
leds_b0 write 0 a2 0000000d 0
misc_out_b0 write 0 a3 12345678 0
ctrl_rb_b0 read 0 11 12345678 00000005
ctrl_rb_b1_idle read 1 11 0 0
leds_b1 write 1 a2 00000003 0
misc_out_b1 write 1 a3 cafef00d 0
gpio_out_b1 write 1 a0 5a5a0001 0
ctrl_rb_b1 read 1 11 cafef00d 00000003
ctrl_rb_b0_kept read 0 11 12345678 00000005
unmapped_write write 0 a7 ffffffff 0
ctrl_rb_b0_after read 0 11 12345678 00000005
misc_in_b0 drive 0 0 a5a5a5a5 0f0f0f0f
misc_rb_b0 read 0 10 a5a5a5a5 0f0f0f0f
misc_in_b1 drive 1 0 11223344 55667788
misc_rb_b1 read 1 10 11223344 55667788
misc_rb_b0_kept read 0 10 a5a5a5a5 0f0f0f0f
rx_plain_b0 rx 0 20 0 0
rx_fe_ch0_b0 write 0 e0 00000001 0
rx_fe_ch1_b0 write 0 f0 00000002 0
rx_fe_b0 rx 0 20 0 0
rx_fe_ch0_b1 write 1 e0 00000003 0
rx_fe_b1 rx 1 20 0 0
tx_plain_b0 tx 0 20 0 0
tx_fe_b1 write 1 d0 00000003 0
tx_fe_run_b1 tx 1 20 0 0
tx_fe_b0 write 0 d0 00000003 0
chip_b0 chip 0 810 0 0
ctrl_rb_chip_b0 read 0 11 12345678 00000015
